/* simd_alu.f */
verilog/simd_pkg.sv
verilog/simd_lane_addsat.sv
verilog/simd_addsat_unit.sv
verilog/simd_shift_unit.sv
verilog/simd_exec_pipe.sv
verilog/simd_credit_fifo.sv
verilog/simd_alu_top.sv
tb/simd_alu_checker.sv
tb/simd_alu_tb.sv

/* Bender.yml */
package:
  name: simd_alu

sources:
  - verilog/simd_pkg.sv
  - verilog/simd_lane_addsat.sv
  - verilog/simd_addsat_unit.sv
  - verilog/simd_shift_unit.sv
  - verilog/simd_exec_pipe.sv
  - verilog/simd_credit_fifo.sv
  - verilog/simd_alu_top.sv
  - target: test
    files:
      - tb/simd_alu_checker.sv
      - tb/simd_alu_tb.sv

/* tb/simd_alu_tb.sv */
// Testbench for the packed-SIMD execution unit.
// Random requests under upstream credits, a lane-level reference model,
// a credit-returning consumer with long stalls, and the final report.
`default_nettype none

module simd_alu_tb import simd_pkg::*; ();

  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int N_REQ       = 400;
  localparam int IDLE_LIMIT  = 200;   // Cycles without an upstream credit.
  localparam int DRAIN_LIMIT = 2000;

  logic       clk;
  logic       rst;
  logic       req_valid;
  simd_req_t  req;
  logic       in_credit;
  logic       rsp_valid;
  simd_rsp_t  rsp;
  logic       out_credit;

  integer     seed;
  int         up_credits;  // Requests the upstream may still send.
  int         dn_owed;     // Responses taken but not yet credited back.
  int         hold;        // Cycles left in a stretch of withheld credits.
  logic [7:0] next_tag;
  simd_rsp_t  exp_q[$];
  int         mismatch_errs;
  int         timeout_errs;
  int         other_errs;

  simd_alu_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .in_credit (in_credit),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Sign bit of every lane set, nothing else.
  function automatic logic [63:0] sign_bits(simd_width_e w);
    case (w)
      w8:      return 64'h8080_8080_8080_8080;
      w16:     return 64'h8000_8000_8000_8000;
      w32:     return 64'h8000_0000_8000_0000;
      default: return 64'h8000_0000_0000_0000;
    endcase
  endfunction

  function automatic logic [63:0] pick_operand(simd_width_e w);
    logic [31:0] sel;
    sel = {$random(seed)} % 8;
    case (sel)
      0:       return '1;
      1:       return sign_bits(w);
      2:       return '0;
      3:       return ~sign_bits(w);  // Largest positive value in each lane.
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  // One lane of lw bits, worked out on wide signed integers.
  function automatic logic [63:0] model_lane(simd_op_e op, int lw, logic [63:0] x,
                                             logic [63:0] y);
    logic [63:0]        mask;
    logic signed [65:0] ux;
    logic signed [65:0] uy;
    logic signed [65:0] sx;
    logic signed [65:0] sy;
    logic signed [65:0] umax;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic signed [65:0] r;
    int                 sh;
    mask = (lw == 64) ? '1 : (64'd1 << lw) - 64'd1;
    ux   = $signed({2'b00, x & mask});
    uy   = $signed({2'b00, y & mask});
    umax = $signed({2'b00, mask});
    smax = (66'sd1 <<< (lw - 1)) - 66'sd1;
    smin = -(66'sd1 <<< (lw - 1));
    sx   = (ux > smax) ? ux - (66'sd1 <<< lw) : ux;  // Above the positive range means negative.
    sy   = (uy > smax) ? uy - (66'sd1 <<< lw) : uy;
    sh   = int'(y & (lw - 1));
    case (op)
      padd:    r = ux + uy;
      psub:    r = ux - uy;
      paddsat: r = (ux + uy > umax) ? umax : ux + uy;
      psubsat: r = (uy > ux) ? 66'sd0 : ux - uy;
      paddsats, psubsats: begin
        r = (op == paddsats) ? sx + sy : sx - sy;
        r = (r > smax) ? smax : ((r < smin) ? smin : r);
      end
      pmin:    r = (ux < uy) ? ux : uy;
      pmax:    r = (ux > uy) ? ux : uy;
      pmins:   r = (sx < sy) ? sx : sy;
      pmaxs:   r = (sx > sy) ? sx : sy;
      pcmpeq:  r = (ux == uy) ? umax : 66'sd0;
      pcmpgt:  r = (sx > sy) ? umax : 66'sd0;
      pshl:    r = ux << sh;
      pshr:    r = ux >> sh;
      psar:    r = sx >>> sh;
      default: r = '0;
    endcase
    return r[63:0] & mask;
  endfunction

  function automatic logic [63:0] model_result(simd_req_t r);
    logic [63:0] res;
    int          lw;
    case (r.op)
      pand:    return r.a & r.b;
      por:     return r.a | r.b;
      pxor:    return r.a ^ r.b;
      pandn:   return r.a & ~r.b;
      pnor:    return ~(r.a | r.b);
      pxnor:   return ~(r.a ^ r.b);
      pmov:    return r.b;
      pnot:    return ~r.b;
      default: ;
    endcase
    lw  = 8 << r.width;
    res = '0;
    for (int i = 0; i < 64 / lw; i++) begin
      res |= model_lane(r.op, lw, r.a >> (i * lw), r.b >> (i * lw)) << (i * lw);
    end
    return res;
  endfunction

  // One clock edge; the consumer decides on a credit return at every edge.
  task automatic tick();
    @(posedge clk);
    if (hold > 0) begin
      hold--;
      out_credit <= 1'b0;
    end else if (dn_owed > 0 && ({$random(seed)} % 3) != 0) begin
      out_credit <= 1'b1;
      dn_owed--;
    end else begin
      out_credit <= 1'b0;
      if (({$random(seed)} % 48) == 0) begin
        hold = 20 + {$random(seed)} % 50;  // Long stall that fills the buffer.
      end
    end
  endtask

  task automatic send_request();
    simd_req_t   r;
    simd_rsp_t   e;
    logic [31:0] op_idx;
    op_idx  = {$random(seed)} % 23;
    r.tag   = next_tag;
    r.op    = simd_op_e'(op_idx[4:0]);
    r.width = simd_width_e'(2'($random(seed)));
    r.a     = pick_operand(r.width);
    r.b     = pick_operand(r.width);
    e.tag   = r.tag;
    e.res   = model_result(r);
    exp_q.push_back(e);
    req       <= r;
    req_valid <= 1'b1;
    next_tag   = next_tag + 8'd1;
    up_credits--;
  endtask

  task automatic compare_rsp(simd_rsp_t got, simd_rsp_t exp);
    if (got.tag !== exp.tag) begin
      $display("Mismatch rsp.tag: got %h, expected %h", got.tag, exp.tag);
      mismatch_errs++;
    end
    if (got.res !== exp.res) begin
      $display("Mismatch rsp.res (tag %h): got %h, expected %h", exp.tag, got.res, exp.res);
      mismatch_errs++;
    end
  endtask

  task automatic compare_credit(int got, int exp);
    if (got != exp) begin
      $display("Mismatch up_credits: got %h, expected %h", got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  // Outputs are sampled in the middle of the cycle.
  always @(negedge clk) begin
    if (!rst) begin
      if (in_credit) up_credits++;
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no request outstanding.");
          other_errs++;
        end else begin
          compare_rsp(rsp, exp_q.pop_front());
        end
        dn_owed++;
      end
    end
  end

  initial begin : main
    int sent;
    int idle;
    int wait_cnt;
    seed          = 32'hafcb;
    up_credits    = FIFO_DEPTH;
    dn_owed       = 0;
    hold          = 0;
    next_tag      = 8'd0;
    mismatch_errs = 0;
    timeout_errs  = 0;
    other_errs    = 0;
    rst           = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    out_credit    = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Nothing has been sent yet, so both outputs stay quiet.
    for (int i = 0; i < 3; i++) begin
      tick();
      @(negedge clk);
      compare_flag("rsp_valid", rsp_valid, 1'b0);
      compare_flag("in_credit", in_credit, 1'b0);
    end

    sent = 0;
    idle = 0;
    while (sent < N_REQ && idle < IDLE_LIMIT) begin
      tick();
      if (up_credits > 0 && ({$random(seed)} % 4) != 0) begin
        send_request();
        sent++;
        idle = 0;
      end else begin
        req_valid <= 1'b0;
        if (up_credits == 0) idle++;
      end
    end
    if (sent < N_REQ) begin
      $display("Timeout: no upstream credit came back within %0d cycles.", IDLE_LIMIT);
      timeout_errs++;
    end
    tick();
    req_valid <= 1'b0;

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      tick();
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d responses never arrived.", exp_q.size());
      timeout_errs++;
    end
    tick();
    tick();
    @(negedge clk);
    compare_credit(up_credits, FIFO_DEPTH);

    $display("Mismatches: %0d, timeouts: %0d, other errors: %0d, assertion failures: %0d",
             mismatch_errs, timeout_errs, other_errs, dut0.chk0.fail_count);
    if (mismatch_errs + timeout_errs + other_errs + dut0.chk0.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/simd_alu_checker.sv */
// Concurrent assertions on the credit and handshake rules of the SIMD unit.
// Bound into the top level of the design.
`default_nettype none

module simd_alu_checker import simd_pkg::*; #(
  parameter int OUT_CREDITS = 2
) (
  input logic      clk,
  input logic      rst,
  input logic      wr_valid,
  input logic      fifo_full,
  input logic      in_credit,
  input logic      out_credit,
  input logic      rsp_valid,
  input simd_rsp_t rsp
);

  int avail;  // Downstream credits the unit holds.
  int fail_count = 0;  // Number of failed assertions.

  always_ff @(posedge clk) begin
    if (rst) begin
      avail <= OUT_CREDITS;
    end else begin
      avail <= avail + int'(out_credit) - int'(rsp_valid);
    end
  end

  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    wr_valid |-> !fifo_full) else begin
    $error("Result written into a full response buffer.");
    fail_count++;
  end

  rsp_needs_credit: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> avail > 0) else begin
    $error("Response sent without a downstream credit.");
    fail_count++;
  end

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !in_credit && !rsp_valid) else begin
    $error("Outputs active right after reset.");
    fail_count++;
  end

  rsp_known: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> !$isunknown(rsp)) else begin
    $error("Response holds unknown bits.");
    fail_count++;
  end

endmodule

bind simd_alu_top simd_alu_checker #(
  .OUT_CREDITS(OUT_CREDITS)
) chk0 (
  .clk       (clk),
  .rst       (rst),
  .wr_valid  (pipe_valid),
  .fifo_full (u_fifo.count == FIFO_DEPTH),
  .in_credit (in_credit),
  .out_credit(out_credit),
  .rsp_valid (rsp_valid),
  .rsp       (rsp)
);

`default_nettype wire

/* verilog/simd_alu_top.sv */
// Top level of the packed-SIMD execution unit.
// Joins the execution pipeline to the credit-controlled response buffer.
`default_nettype none

module simd_alu_top import simd_pkg::*; #(
  parameter int FIFO_DEPTH  = 4,  // Also the upstream credits after reset.
  parameter int OUT_CREDITS = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  simd_req_t req,
  output logic      in_credit,
  output logic      rsp_valid,
  output simd_rsp_t rsp,
  input  logic      out_credit
);

  logic      pipe_valid;
  simd_rsp_t pipe_rsp;

  // Results reach the buffer two edges after the request is sampled.
  simd_exec_pipe u_pipe (
    .clk      (clk),
    .rst      (rst),
    .req_valid(req_valid),
    .req      (req),
    .res_valid(pipe_valid),
    .res      (pipe_rsp)
  );

  // The pipeline never stalls, so the buffer takes every result.
  simd_credit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_valid  (pipe_valid),
    .wr_data   (pipe_rsp),
    .in_credit (in_credit),
    .out_credit(out_credit),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* verilog/simd_credit_fifo.sv */
// Response buffer with credit flow control on both sides.
// Every pop returns one upstream credit and spends one downstream credit.
`default_nettype none

module simd_credit_fifo import simd_pkg::*; #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_valid,
  input  simd_rsp_t wr_data,
  output logic      in_credit,
  input  logic      out_credit,
  output logic      rsp_valid,
  output simd_rsp_t rsp
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  simd_rsp_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;  // Responses the downstream can still take.
  logic             pop;

  // The head leaves in every cycle that has an entry and a credit.
  assign pop       = (count != '0) && (credits != '0);
  assign rsp_valid = pop;
  assign rsp       = mem[rd_ptr];

  // Upstream credits guarantee a free slot for every write.
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= CRD_W'(OUT_CREDITS);
      in_credit <= 1'b0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CNT_W'(wr_valid) - CNT_W'(pop);
      credits   <= credits + CRD_W'(out_credit) - CRD_W'(pop);
      in_credit <= pop;  // Frees the slot for the upstream one cycle after the pop.
    end
  end

endmodule

`default_nettype wire

/* verilog/simd_exec_pipe.sv */
// Two-stage execution pipeline.
// Stage 1 decodes and registers the request; stage 2 computes the logic
// group, picks the result of the operation's group and registers it.
`default_nettype none

module simd_exec_pipe import simd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  simd_req_t req,
  output logic      res_valid,
  output simd_rsp_t res
);

  typedef enum logic [1:0] {
    grp_arith,
    grp_logic,
    grp_shift
  } simd_grp_e;

  simd_lane_ctl_t         dec_ctl;
  simd_grp_e              dec_grp;
  logic                   s1_valid;
  simd_req_t              s1_req;
  simd_lane_ctl_t         s1_ctl;
  simd_grp_e              s1_grp;
  logic [SIMD_DATA_W-1:0] arith_res;
  logic [SIMD_DATA_W-1:0] shift_res;
  logic [SIMD_DATA_W-1:0] logic_res;
  logic [SIMD_DATA_W-1:0] sel_res;

  // Min, max and the compares all use the adder as a subtractor.
  always_comb begin
    dec_ctl.is_sign = req.op inside {paddsats, psubsats, pmins, pmaxs, pcmpgt};
    dec_ctl.is_sat  = req.op inside {paddsat, psubsat, paddsats, psubsats};
    dec_ctl.is_sub  = req.op inside {psub, psubsat, psubsats, pmin, pmax, pmins, pmaxs,
                                     pcmpeq, pcmpgt};
    dec_ctl.is_min  = req.op inside {pmin, pmins};
    dec_ctl.is_max  = req.op inside {pmax, pmaxs};
    dec_ctl.is_eq   = (req.op == pcmpeq);
    dec_ctl.is_gt   = (req.op == pcmpgt);
    if (req.op inside {pshl, pshr, psar}) begin
      dec_grp = grp_shift;
    end else if (req.op inside {pand, por, pxor, pandn, pnor, pxnor, pmov, pnot}) begin
      dec_grp = grp_logic;
    end else begin
      dec_grp = grp_arith;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_req <= req;
    s1_ctl <= dec_ctl;
    s1_grp <= dec_grp;
  end

  simd_addsat_unit u_addsat (
    .a    (s1_req.a),
    .b    (s1_req.b),
    .ctl  (s1_ctl),
    .width(s1_req.width),
    .res  (arith_res)
  );

  simd_shift_unit u_shift (
    .a    (s1_req.a),
    .b    (s1_req.b),
    .op   (s1_req.op),
    .width(s1_req.width),
    .res  (shift_res)
  );

  // The logic group works on the whole word, so lane width plays no part.
  always_comb begin
    case (s1_req.op)
      pand:    logic_res = s1_req.a & s1_req.b;
      por:     logic_res = s1_req.a | s1_req.b;
      pxor:    logic_res = s1_req.a ^ s1_req.b;
      pandn:   logic_res = s1_req.a & ~s1_req.b;
      pnor:    logic_res = ~(s1_req.a | s1_req.b);
      pxnor:   logic_res = s1_req.a ~^ s1_req.b;
      pmov:    logic_res = s1_req.b;
      pnot:    logic_res = ~s1_req.b;
      default: logic_res = '0;
    endcase
  end

  always_comb begin
    case (s1_grp)
      grp_shift: sel_res = shift_res;
      grp_logic: sel_res = logic_res;
      default:   sel_res = arith_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    res.tag <= s1_req.tag;
    res.res <= sel_res;
  end

endmodule

`default_nettype wire

/* verilog/simd_shift_unit.sv */
// Per-lane shifts for all four lane widths.
// Left and logical right fill with zero; arithmetic right fills with the sign.
`default_nettype none

module simd_shift_unit import simd_pkg::*; (
  input  logic [SIMD_DATA_W-1:0] a,
  input  logic [SIMD_DATA_W-1:0] b,
  input  simd_op_e               op,
  input  simd_width_e            width,
  output logic [SIMD_DATA_W-1:0] res
);

  logic [3:0][SIMD_DATA_W-1:0] width_res;

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int LW    = 8 << w;
    localparam int SW    = $clog2(LW);  // Shift amount bits per lane.
    localparam int LANES = SIMD_DATA_W / LW;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [LW-1:0] lane_a;
      logic [SW-1:0] amt;
      logic [LW-1:0] lane_res;

      assign lane_a = a[l*LW +: LW];
      assign amt    = b[l*LW +: SW];  // The amount sits in the low bits of the same lane.

      always_comb begin
        case (op)
          pshr:    lane_res = lane_a >> amt;
          psar:    lane_res = $signed(lane_a) >>> amt;
          default: lane_res = lane_a << amt;
        endcase
      end

      assign width_res[w][l*LW +: LW] = lane_res;
    end
  end

  always_comb begin
    case (width)
      w8:      res = width_res[0];
      w16:     res = width_res[1];
      w32:     res = width_res[2];
      default: res = width_res[3];
    endcase
  end

endmodule

`default_nettype wire

/* verilog/simd_addsat_unit.sv */
// Add/saturate unit across the whole word.
// Builds lanes of 8, 16, 32 and 64 bits and returns the requested width.
`default_nettype none

module simd_addsat_unit import simd_pkg::*; (
  input  logic [SIMD_DATA_W-1:0] a,
  input  logic [SIMD_DATA_W-1:0] b,
  input  simd_lane_ctl_t         ctl,
  input  simd_width_e            width,
  output logic [SIMD_DATA_W-1:0] res
);

  // One full word of lane results per lane width.
  logic [3:0][SIMD_DATA_W-1:0] width_res;

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int LW    = 8 << w;
    localparam int LANES = SIMD_DATA_W / LW;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
      simd_lane_addsat #(
        .WIDTH(LW)
      ) u_lane (
        .a  (a[l*LW +: LW]),
        .b  (b[l*LW +: LW]),
        .ctl(ctl),
        .res(width_res[w][l*LW +: LW])
      );
    end
  end

  always_comb begin
    case (width)
      w8:      res = width_res[0];
      w16:     res = width_res[1];
      w32:     res = width_res[2];
      default: res = width_res[3];
    endcase
  end

endmodule

`default_nettype wire

/* verilog/simd_lane_addsat.sv */
// One lane of add, subtract, saturation, min, max and compare.
// The lane width is a parameter; a single adder serves every operation.
`default_nettype none

module simd_lane_addsat import simd_pkg::*; #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  simd_lane_ctl_t   ctl,
  output logic [WIDTH-1:0] res
);

  localparam int MSB = WIDTH - 1;

  logic [WIDTH-1:0] b_op;
  logic [WIDTH-1:0] sum;
  logic [WIDTH-1:0] sat_val;
  logic             cout;
  logic             uns_ovf;
  logic             sgn_ovf;
  logic             sat_hit;
  logic             a_lt_b;
  logic             a_eq_b;

  // Subtraction is a plus inverted b plus one.
  assign b_op = ctl.is_sub ? ~b : b;
  assign {cout, sum} = {1'b0, a} + {1'b0, b_op} + {{WIDTH{1'b0}}, ctl.is_sub};

  // On subtract a clear carry means a borrow.
  assign uns_ovf = ctl.is_sub ? ~cout : cout;

  // Operands of equal sign giving a result of the other sign overflowed.
  assign sgn_ovf = (a[MSB] == b_op[MSB]) && (sum[MSB] != a[MSB]);

  // Order of a and b, taken from the difference. Only valid when subtracting.
  assign a_lt_b = ctl.is_sign ? (sum[MSB] ^ sgn_ovf) : ~cout;
  assign a_eq_b = (sum == '0);

  assign sat_hit = ctl.is_sign ? sgn_ovf : uns_ovf;

  always_comb begin
    if (ctl.is_sign) begin
      // An overflow keeps the sign of a, so a positive a clamps high.
      sat_val = a[MSB] ? {1'b1, {MSB{1'b0}}} : {1'b0, {MSB{1'b1}}};
    end else begin
      sat_val = ctl.is_sub ? {WIDTH{1'b0}} : {WIDTH{1'b1}};
    end
  end

  always_comb begin
    if (ctl.is_eq) begin
      res = {WIDTH{a_eq_b}};
    end else if (ctl.is_gt) begin
      res = {WIDTH{~a_lt_b & ~a_eq_b}};  // Greater means neither less nor equal.
    end else if (ctl.is_min) begin
      res = a_lt_b ? a : b;
    end else if (ctl.is_max) begin
      res = a_lt_b ? b : a;
    end else if (ctl.is_sat && sat_hit) begin
      res = sat_val;
    end else begin
      res = sum;  // Wrapping add and subtract, and in-range saturating results.
    end
  end

endmodule

`default_nettype wire

/* verilog/simd_pkg.sv */
// Shared types of the packed-SIMD execution unit.
// Holds the opcode and lane-width encodings, the decoded lane controls
// and the request and response structs.
`default_nettype none

package simd_pkg;

  // Width of one operand word.
  localparam int SIMD_DATA_W = 64;

  // Opcodes. The first twelve run through the lane adders.
  typedef enum logic [4:0] {
    padd,
    psub,
    paddsat,   // Unsigned saturating add.
    psubsat,   // Unsigned saturating subtract.
    paddsats,  // Signed saturating add.
    psubsats,  // Signed saturating subtract.
    pmin,
    pmax,
    pmins,
    pmaxs,
    pcmpeq,
    pcmpgt,    // Signed greater-than.
    pand,
    por,
    pxor,
    pandn,     // A and not B.
    pnor,
    pxnor,
    pmov,      // Copies B.
    pnot,      // Inverts B.
    pshl,
    pshr,
    psar
  } simd_op_e;

  // Lane width of an operation.
  typedef enum logic [1:0] {
    w8  = 2'd0,
    w16 = 2'd1,
    w32 = 2'd2,
    w64 = 2'd3
  } simd_width_e;

  // Controls for one add/saturate lane, decoded from the opcode.
  typedef struct packed {
    logic is_sign;  // Signed compare and saturation.
    logic is_sat;
    logic is_sub;   // Adder computes a minus b.
    logic is_min;
    logic is_max;
    logic is_eq;
    logic is_gt;
  } simd_lane_ctl_t;

  typedef struct packed {
    logic [7:0]             tag;
    simd_op_e               op;
    simd_width_e            width;
    logic [SIMD_DATA_W-1:0] a;
    logic [SIMD_DATA_W-1:0] b;
  } simd_req_t;

  typedef struct packed {
    logic [7:0]             tag;
    logic [SIMD_DATA_W-1:0] res;
  } simd_rsp_t;

endpackage

`default_nettype wire
